// File: Bender.yml
package:
  name: md_bus

sources:
  - logic/md_pkg.sv
  - logic/work_ram.sv
  - logic/audio_mixer.sv
  - logic/bus_arbiter.sv
  - logic/bus_fabric.sv
  - logic/cpu_bus_port.sv
  - logic/block_dma.sv
  - logic/md_bus_top.sv
  - target: test
    files:
      - bench/tb_md_bus.sv

// File: all.f
logic/md_pkg.sv
logic/work_ram.sv
logic/audio_mixer.sv
logic/bus_arbiter.sv
logic/bus_fabric.sv
logic/cpu_bus_port.sv
logic/block_dma.sv
logic/md_bus_top.sv
bench/tb_md_bus.sv

// File: bench/tb_md_bus.sv
`timescale 1ns/1ps
`default_nettype none

module tb_md_bus;

	localparam int RAM_AW = 15;
	localparam int PAT_LEN = 2048;
	localparam int RT_WORDS = 24;
	localparam int CPU_LIMIT = 1000;
	localparam int STREAM_LIMIT = 1500;

	// rough length of each test in clock cycles
	localparam int LEN_RESET = 8;
	localparam int LEN_MIXER = 40;
	localparam int LEN_RAM = 600;
	localparam int LEN_UNMAPPED = 140;
	localparam int LEN_BLOCK = 500;
	localparam int LEN_ARB = 360;
	localparam longint WATCHDOG_NS = longint'(LEN_RESET + LEN_MIXER + LEN_RAM +
		LEN_UNMAPPED + LEN_BLOCK + LEN_ARB) * 40 * 4;

	logic                            MCLK2;
	logic                            arst_n;
	logic                            cpu_req;
	logic                            cpu_we;
	logic [md_pkg::VA_W-1:0]         cpu_addr;
	logic [md_pkg::BE_W-1:0]         cpu_be;
	logic [md_pkg::VD_W-1:0]         cpu_wdata;
	logic                            cpu_ack;
	logic [md_pkg::VD_W-1:0]         cpu_rdata;
	logic                            dma_start;
	logic [md_pkg::VA_W-1:0]         dma_src;
	logic [7:0]                      dma_len;
	logic                            dma_ready;
	logic                            dma_valid;
	logic [md_pkg::VD_W-1:0]         dma_data;
	logic                            dma_busy;
	logic                            dma_done;
	logic [md_pkg::FM_W-1:0]         fm_l;
	logic [md_pkg::FM_W-1:0]         fm_r;
	logic [md_pkg::FM2612_W-1:0]     fm2612_l;
	logic [md_pkg::FM2612_W-1:0]     fm2612_r;
	logic [md_pkg::PSG_W-1:0]        psg;
	logic [md_pkg::MIX_W-1:0]        mix_l;
	logic [md_pkg::MIX_W-1:0]        mix_r;
	logic [md_pkg::MIX2612_W-1:0]    mix2612_l;
	logic [md_pkg::MIX2612_W-1:0]    mix2612_r;

	// reference model
	logic [md_pkg::VD_W-1:0] ram_model [2**RAM_AW];
	logic [md_pkg::VD_W-1:0] keeper_model;
	logic                    ready_pat [PAT_LEN];
	logic [md_pkg::VA_W-1:0] arb_addr [3];
	logic [md_pkg::VD_W-1:0] arb_data [3];
	logic [14:0]             rt_idx [RT_WORDS];

	int checks;
	int errors;
	int req_count;
	int ack_seen;

	md_bus_top #(
		.RAM_AW (RAM_AW)
	) md_bus_top_i (
		.MCLK2       (MCLK2),
		.arst_n_i    (arst_n),
		.cpu_req_i   (cpu_req),
		.cpu_we_i    (cpu_we),
		.cpu_addr_i  (cpu_addr),
		.cpu_be_i    (cpu_be),
		.cpu_wdata_i (cpu_wdata),
		.cpu_ack_o   (cpu_ack),
		.cpu_rdata_o (cpu_rdata),
		.dma_start_i (dma_start),
		.dma_src_i   (dma_src),
		.dma_len_i   (dma_len),
		.dma_ready_i (dma_ready),
		.dma_valid_o (dma_valid),
		.dma_data_o  (dma_data),
		.dma_busy_o  (dma_busy),
		.dma_done_o  (dma_done),
		.fm_l_i      (fm_l),
		.fm_r_i      (fm_r),
		.fm2612_l_i  (fm2612_l),
		.fm2612_r_i  (fm2612_r),
		.psg_i       (psg),
		.mix_l_o     (mix_l),
		.mix_r_o     (mix_r),
		.mix2612_l_o (mix2612_l),
		.mix2612_r_o (mix2612_r)
	);

	initial
	begin
		MCLK2 = 1'b0;
		forever #20 MCLK2 = ~MCLK2;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all tests had finished");
		$display("Test FAILED");
		$finish;
	end

	// held word must survive back-pressure
	hold_check: assert property (@(posedge MCLK2) disable iff (!arst_n)
		(dma_valid && !dma_ready) |=> (dma_valid && $stable(dma_data)))
	else
	begin
		$display("held DMA word was dropped or changed while dma_ready_i was low");
		errors++;
	end

	ack_check: assert property (@(posedge MCLK2) disable iff (!arst_n)
		cpu_ack |=> !cpu_ack)
	else
	begin
		$display("cpu_ack_o stayed high for more than one cycle");
		errors++;
	end

	done_check: assert property (@(posedge MCLK2) disable iff (!arst_n)
		dma_done |=> !dma_done)
	else
	begin
		$display("dma_done_o stayed high for more than one cycle");
		errors++;
	end

	// engine keeps ownership for as long as it asks for the bus
	bus_keep_check: assert property (@(posedge MCLK2) disable iff (!arst_n)
		(md_bus_top_i.bus_arbiter_i.state_q == md_pkg::ARB_DMA && md_bus_top_i.dma_want)
		|=> (md_bus_top_i.bus_arbiter_i.state_q == md_pkg::ARB_DMA))
	else
	begin
		$display("bus was taken from the engine while it still wanted it");
		errors++;
	end

	always @(posedge MCLK2)
	begin
		if (cpu_ack === 1'b1)
			ack_seen++;
	end

	task automatic step_cycle();
		@(posedge MCLK2);
		#2;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int c0, input int e0);
		$display("%s: %0d checks, %0d errors", name, checks - c0, errors - e0);
	endtask

	function automatic int ram_index(input logic [md_pkg::VA_W-1:0] a);
		return int'(a[RAM_AW-1:0]);
	endfunction

	// random alias of a ram word in the upper mirror bits
	function automatic logic [md_pkg::VA_W-1:0] mirror_addr(input logic [14:0] idx);
		return {md_pkg::RAM_REGION, 6'($urandom), idx};
	endfunction

	function automatic logic [md_pkg::VA_W-1:0] unmapped_addr();
		return {2'($urandom % 3), 21'($urandom)};
	endfunction

	function automatic logic [15:0] expect_lin(input logic [8:0] fm, input logic [15:0] p);
		int v;
		v = (int'(fm) - 256) * 64 + int'(p);
		return v[15:0];
	endfunction

	function automatic logic [17:0] expect_dac(input logic [9:0] fm, input logic [15:0] p);
		int v;
		v = int'($signed(fm)) * 192 + int'(p);
		return v[17:0];
	endfunction

	// one request, checked against the model, model updated as the bus would be
	task automatic cpu_access(input logic we, input logic [md_pkg::VA_W-1:0] addr,
		input logic [md_pkg::BE_W-1:0] be, input logic [md_pkg::VD_W-1:0] wd);
		logic [md_pkg::VD_W-1:0] expect_rd;
		logic in_ram;
		int idx;
		int n;
		in_ram = (addr[md_pkg::VA_W-1 -: 2] == md_pkg::RAM_REGION);
		idx = ram_index(addr);
		expect_rd = in_ram ? ram_model[idx] : keeper_model;
		cpu_req = 1'b1;
		cpu_we = we;
		cpu_addr = addr;
		cpu_be = be;
		cpu_wdata = wd;
		req_count++;
		n = 0;
		do
		begin
			step_cycle();
			n++;
		end
		while (!cpu_ack && n < CPU_LIMIT);
		if (!cpu_ack)
		begin
			$display("CPU request to address %h was never acknowledged", addr);
			errors++;
		end
		else if (!we)
			check_value("cpu_rdata_o", cpu_rdata, expect_rd);
		cpu_req = 1'b0;
		if (we)
		begin
			keeper_model = wd;
			if (in_ram && be[0])
				ram_model[idx][7:0] = wd[7:0];
			if (in_ram && be[1])
				ram_model[idx][15:8] = wd[15:8];
		end
		else if (in_ram)
			keeper_model = ram_model[idx];
		step_cycle();
	endtask

	task automatic fill_block(input logic [md_pkg::VA_W-1:0] src, input int len);
		int i;
		for (i = 0; i < len; i++)
			cpu_access(1'b1, 23'(src + i), 2'b11, 16'($urandom));
	endtask

	task automatic make_ready_pattern(input int stall_pct);
		int i;
		for (i = 0; i < PAT_LEN; i++)
			ready_pat[i] = (($urandom % 100) >= stall_pct);
	endtask

	// start a transfer and consume the stream with the ready pattern
	task automatic stream_block(input logic [md_pkg::VA_W-1:0] src, input int len);
		logic [md_pkg::VD_W-1:0] expect_q [$];
		logic rdy;
		int i;
		int idx;
		int n;
		int dones;
		for (i = 0; i < len; i++)
			expect_q.push_back(ram_model[ram_index(23'(src + i))]);
		dma_src = src;
		dma_len = 8'(len);
		dma_start = 1'b1;
		step_cycle();
		dma_start = 1'b0;
		idx = 0;
		n = 0;
		dones = 0;
		while (dones == 0 && n < STREAM_LIMIT)
		begin
			if (dma_done)
			begin
				dones++;
				check_value("accepted words", idx, len);
			end
			else
			begin
				check_value("dma_busy_o", dma_busy, 1);
				rdy = ready_pat[n % PAT_LEN];
				dma_ready = rdy;
				if (dma_valid && rdy && idx < len)
					check_value("dma_data_o", dma_data, expect_q[idx]);
				else if (dma_valid && rdy)
				begin
					$display("block transfer sent more words than requested");
					errors++;
				end
				if (dma_valid && rdy)
					idx++;
			end
			step_cycle();
			n++;
		end
		dma_ready = 1'b0;
		if (dones == 0)
		begin
			$display("block transfer from %h never signalled done", src);
			errors++;
		end
		check_value("dma_done_o", dma_done, 0);
		check_value("dma_busy_o", dma_busy, 0);
		if (len > 0)
			keeper_model = expect_q[len-1];
	endtask

	// requests that arrive while the engine owns the bus
	task automatic cpu_during_dma();
		int k;
		repeat (3) step_cycle();
		for (k = 0; k < 3; k++)
		begin
			cpu_access(1'b1, arb_addr[k], 2'b11, arb_data[k]);
			cpu_access(1'b0, arb_addr[k], 2'b00, 16'h0);
		end
	endtask

	initial
	begin
		int i;
		int p;
		int sel;
		int c0;
		int e0;
		logic [md_pkg::VA_W-1:0] src;
		void'($urandom(27629));
		checks = 0;
		errors = 0;
		req_count = 0;
		ack_seen = 0;
		keeper_model = '0;
		arst_n = 1'b0;
		cpu_req = 1'b0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_be = '0;
		cpu_wdata = '0;
		dma_start = 1'b0;
		dma_src = '0;
		dma_len = '0;
		dma_ready = 1'b0;
		// fm at midpoint gives a silent mix
		fm_l = 9'h100;
		fm_r = 9'h100;
		fm2612_l = '0;
		fm2612_r = '0;
		psg = '0;

		c0 = checks;
		e0 = errors;
		for (i = 0; i < 4; i++)
		begin
			if (i < 3)
				step_cycle();
			else
			begin
				arst_n = 1'b1;
				step_cycle();
			end
			check_value("cpu_ack_o", cpu_ack, 0);
			check_value("dma_valid_o", dma_valid, 0);
			check_value("dma_busy_o", dma_busy, 0);
			check_value("dma_done_o", dma_done, 0);
			check_value("mix_l_o", mix_l, 0);
			check_value("mix_r_o", mix_r, 0);
			check_value("mix2612_l_o", mix2612_l, 0);
			check_value("mix2612_r_o", mix2612_r, 0);
		end
		report_test("reset values", c0, e0);

		c0 = checks;
		e0 = errors;
		for (i = 0; i < 32; i++)
		begin
			fm_l = 9'($urandom);
			fm_r = 9'($urandom);
			fm2612_l = 10'($urandom);
			fm2612_r = 10'($urandom);
			psg = 16'($urandom);
			step_cycle();
			check_value("mix_l_o", mix_l, expect_lin(fm_l, psg));
			check_value("mix_r_o", mix_r, expect_lin(fm_r, psg));
			check_value("mix2612_l_o", mix2612_l, expect_dac(fm2612_l, psg));
			check_value("mix2612_r_o", mix2612_r, expect_dac(fm2612_r, psg));
		end
		report_test("mixer", c0, e0);

		// full words first, then partial writes through other mirrors
		c0 = checks;
		e0 = errors;
		for (i = 0; i < RT_WORDS; i++)
		begin
			rt_idx[i] = 15'($urandom);
			cpu_access(1'b1, mirror_addr(rt_idx[i]), 2'b11, 16'($urandom));
		end
		for (p = 0; p < 2; p++)
			for (i = 0; i < RT_WORDS; i++)
				cpu_access(1'b1, mirror_addr(rt_idx[i]), 2'($urandom), 16'($urandom));
		for (i = 0; i < RT_WORDS; i++)
			cpu_access(1'b0, mirror_addr(rt_idx[i]), 2'b00, 16'h0);
		report_test("ram round trip", c0, e0);

		c0 = checks;
		e0 = errors;
		cpu_access(1'b0, unmapped_addr(), 2'b00, 16'h0);
		for (i = 0; i < 20; i++)
		begin
			sel = $urandom % 4;
			if (sel < 2)
				cpu_access(1'b0, unmapped_addr(), 2'b00, 16'h0);
			else if (sel == 2)
				cpu_access(1'b1, unmapped_addr(), 2'($urandom), 16'($urandom));
			else
				cpu_access(1'b0, mirror_addr(rt_idx[$urandom % RT_WORDS]), 2'b00, 16'h0);
		end
		report_test("unmapped reads", c0, e0);

		// source crosses the top of the ram index into the next mirror
		c0 = checks;
		e0 = errors;
		src = {md_pkg::RAM_REGION, 6'h05, 15'h7ff0};
		fill_block(src, 40);
		make_ready_pattern(40);
		stream_block(src, 40);
		report_test("block transfer", c0, e0);

		c0 = checks;
		e0 = errors;
		src = {md_pkg::RAM_REGION, 6'h11, 15'h2000};
		fill_block(src, 24);
		for (i = 0; i < 3; i++)
		begin
			arb_addr[i] = {md_pkg::RAM_REGION, 6'h3c, 15'(15'h5000 + i)};
			arb_data[i] = 16'($urandom);
		end
		make_ready_pattern(30);
		fork
			stream_block(src, 24);
			cpu_during_dma();
		join
		step_cycle();
		check_value("cpu_ack_o pulse count", ack_seen, req_count);
		report_test("arbitration", c0, e0);

		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/audio_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module audio_mixer (
	input  wire                           MCLK2,
	input  wire                           arst_n_i,
	input  wire [md_pkg::FM_W-1:0]        fm_l_i,
	input  wire [md_pkg::FM_W-1:0]        fm_r_i,
	input  wire [md_pkg::FM2612_W-1:0]    fm2612_l_i,
	input  wire [md_pkg::FM2612_W-1:0]    fm2612_r_i,
	input  wire [md_pkg::PSG_W-1:0]       psg_i,
	output logic [md_pkg::MIX_W-1:0]      mix_l_o,
	output logic [md_pkg::MIX_W-1:0]      mix_r_o,
	output logic [md_pkg::MIX2612_W-1:0]  mix2612_l_o,
	output logic [md_pkg::MIX2612_W-1:0]  mix2612_r_o
);

	// (fm - 256) * 64 + psg
	function automatic logic [md_pkg::MIX_W-1:0] mix_lin(
		input logic [md_pkg::FM_W-1:0]  fm,
		input logic [md_pkg::PSG_W-1:0] psg
	);
		logic [md_pkg::FM_W-1:0] fm_s;
		// offset binary to two's complement is a flip of the top bit
		fm_s = {~fm[md_pkg::FM_W-1], fm[md_pkg::FM_W-2:0]};
		return {fm_s[md_pkg::FM_W-1], fm_s, 6'd0} + psg;
	endfunction

	// fm * 192 + psg, built as *128 plus *64
	function automatic logic [md_pkg::MIX2612_W-1:0] mix_dac(
		input logic [md_pkg::FM2612_W-1:0] fm,
		input logic [md_pkg::PSG_W-1:0]    psg
	);
		return {fm[md_pkg::FM2612_W-1], fm, 7'd0} +
			{{2{fm[md_pkg::FM2612_W-1]}}, fm, 6'd0} + {2'd0, psg};
	endfunction

	always_ff @(posedge MCLK2 or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			mix_l_o <= '0;
			mix_r_o <= '0;
			mix2612_l_o <= '0;
			mix2612_r_o <= '0;
		end
		else
		begin
			mix_l_o <= mix_lin(fm_l_i, psg_i);
			mix_r_o <= mix_lin(fm_r_i, psg_i);
			mix2612_l_o <= mix_dac(fm2612_l_i, psg_i);
			mix2612_r_o <= mix_dac(fm2612_r_i, psg_i);
		end
	end

endmodule

`default_nettype wire

// File: logic/block_dma.sv
`timescale 1ns/1ps
`default_nettype none

module block_dma (
	input  wire                      MCLK2,
	input  wire                      arst_n_i,
	input  wire                      dma_start_i,
	input  wire [md_pkg::VA_W-1:0]   dma_src_i,
	input  wire [7:0]                dma_len_i,
	input  wire                      dma_ready_i,
	input  wire                      grant_i,
	input  wire                      bus_ack_i,
	input  wire [md_pkg::VD_W-1:0]   bus_rdata_i,
	output logic                     want_o,
	output logic                     strobe_o,
	output logic [md_pkg::VA_W-1:0]  addr_o,
	output logic                     dma_valid_o,
	output logic [md_pkg::VD_W-1:0]  dma_data_o,
	output logic                     dma_busy_o,
	output logic                     dma_done_o
);

	md_pkg::dma_state_e        state_q;
	logic [md_pkg::VA_W-1:0]   addr_q;
	logic [7:0]                left_q;
	logic [md_pkg::VD_W-1:0]   word_q;
	logic                      beat;

	assign strobe_o = (state_q == md_pkg::DMA_READ) & grant_i;
	assign beat = strobe_o & bus_ack_i;

	// hold the bus across back-pressure unless the last word is already in
	assign want_o = (state_q == md_pkg::DMA_READ) |
		((state_q == md_pkg::DMA_HOLD) & (left_q != 8'd0));

	assign addr_o = addr_q;
	assign dma_valid_o = (state_q == md_pkg::DMA_HOLD);
	assign dma_data_o = word_q;
	assign dma_busy_o = (state_q != md_pkg::DMA_IDLE);
	assign dma_done_o = (state_q == md_pkg::DMA_DONE);

	always_ff @(posedge MCLK2 or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state_q <= md_pkg::DMA_IDLE;
			addr_q <= '0;
			left_q <= '0;
		end
		else
		begin
			case (state_q)
				md_pkg::DMA_IDLE:
					if (dma_start_i)
					begin
						addr_q <= dma_src_i;
						left_q <= dma_len_i;
						state_q <= md_pkg::DMA_READ;
					end
				md_pkg::DMA_READ:
					if (beat)
					begin
						addr_q <= addr_q + 1'b1;
						left_q <= left_q - 1'b1;
						state_q <= md_pkg::DMA_HOLD;
					end
				md_pkg::DMA_HOLD:
					if (dma_ready_i)
						state_q <= (left_q == 8'd0) ? md_pkg::DMA_DONE : md_pkg::DMA_READ;
				default:
					state_q <= md_pkg::DMA_IDLE;
			endcase
		end
	end

	// one word in flight
	always_ff @(posedge MCLK2)
	begin
		if (beat)
			word_q <= bus_rdata_i;
	end

endmodule

`default_nettype wire

// File: logic/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input  wire  MCLK2,
	input  wire  arst_n_i,
	input  wire  cpu_want_i,
	input  wire  dma_want_i,
	input  wire  bus_busy_i,
	output logic cpu_grant_o,
	output logic dma_grant_o
);

	md_pkg::arb_state_e state_q;
	md_pkg::arb_state_e state_d;

	// owner only changes between bus cycles
	// engine wins a free boundary and keeps the bus while it wants it
	always_comb
	begin
		state_d = state_q;
		if (!bus_busy_i)
		begin
			if (dma_want_i)
				state_d = md_pkg::ARB_DMA;
			else
				state_d = md_pkg::ARB_CPU;
		end
	end

	always_ff @(posedge MCLK2 or negedge arst_n_i)
	begin
		if (!arst_n_i)
			state_q <= md_pkg::ARB_CPU;
		else
			state_q <= state_d;
	end

	// cpu port owns the bus by default, granted only while it has a request
	assign cpu_grant_o = (state_q == md_pkg::ARB_CPU) & cpu_want_i;
	assign dma_grant_o = (state_q == md_pkg::ARB_DMA);

endmodule

`default_nettype wire

// File: logic/bus_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module bus_fabric (
	input  wire                      MCLK2,
	input  wire                      arst_n_i,
	input  wire                      cpu_grant_i,
	input  wire                      dma_grant_i,
	input  wire                      cpu_stb_i,
	input  wire                      cpu_we_i,
	input  wire [md_pkg::VA_W-1:0]   cpu_addr_i,
	input  wire [md_pkg::BE_W-1:0]   cpu_be_i,
	input  wire [md_pkg::VD_W-1:0]   cpu_wdata_i,
	input  wire                      dma_stb_i,
	input  wire [md_pkg::VA_W-1:0]   dma_addr_i,
	input  wire                      ram_ack_i,
	input  wire [md_pkg::VD_W-1:0]   ram_rdata_i,
	output logic                     ram_sel_o,
	output logic                     ram_we_o,
	output logic [md_pkg::VA_W-1:0]  ram_addr_o,
	output logic [md_pkg::BE_W-1:0]  ram_be_o,
	output logic [md_pkg::VD_W-1:0]  ram_wdata_o,
	output logic                     bus_ack_o,
	output logic [md_pkg::VD_W-1:0]  bus_rdata_o,
	output logic                     bus_busy_o
);

	logic                      own_stb;
	logic                      own_we;
	logic [md_pkg::VA_W-1:0]   own_addr;
	logic [md_pkg::BE_W-1:0]   own_be;
	logic [md_pkg::VD_W-1:0]   own_wdata;
	logic                      in_ram;
	logic                      new_cycle;
	logic                      unmap_ack_q;
	logic [md_pkg::VD_W-1:0]   keeper_q;

	// owner mux
	// engine leg is a fixed full-word read
	always_comb
	begin
		own_stb = 1'b0;
		own_we = 1'b0;
		own_addr = cpu_addr_i;
		own_be = cpu_be_i;
		own_wdata = cpu_wdata_i;
		if (dma_grant_i)
		begin
			own_stb = dma_stb_i;
			own_addr = dma_addr_i;
			own_be = '1;
			own_wdata = '0;
		end
		else if (cpu_grant_i)
		begin
			own_stb = cpu_stb_i;
			own_we = cpu_we_i;
		end
	end

	assign in_ram = (own_addr[md_pkg::VA_W-1 -: 2] == md_pkg::RAM_REGION);

	// strobe stays up through the ack cycle, so only its first cycle counts
	assign new_cycle = own_stb & ~bus_ack_o;

	assign ram_sel_o = new_cycle & in_ram;
	assign ram_we_o = own_we;
	assign ram_addr_o = own_addr;
	assign ram_be_o = own_be;
	assign ram_wdata_o = own_wdata;

	assign bus_ack_o = ram_ack_i | unmap_ack_q;
	assign bus_rdata_o = ram_ack_i ? ram_rdata_i : keeper_q;
	assign bus_busy_o = own_stb | bus_ack_o;

	always_ff @(posedge MCLK2 or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			unmap_ack_q <= 1'b0;
			keeper_q <= '0;
		end
		else
		begin
			unmap_ack_q <= new_cycle & ~in_ram;
			// bus holds the last word driven onto it
			if (new_cycle & own_we)
				keeper_q <= own_wdata;
			else if (ram_ack_i & ~own_we)
				keeper_q <= ram_rdata_i;
		end
	end

endmodule

`default_nettype wire

// File: logic/cpu_bus_port.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_port (
	input  wire                      MCLK2,
	input  wire                      arst_n_i,
	input  wire                      cpu_req_i,
	input  wire                      cpu_we_i,
	input  wire [md_pkg::VA_W-1:0]   cpu_addr_i,
	input  wire [md_pkg::BE_W-1:0]   cpu_be_i,
	input  wire [md_pkg::VD_W-1:0]   cpu_wdata_i,
	input  wire                      grant_i,
	input  wire                      bus_ack_i,
	input  wire [md_pkg::VD_W-1:0]   bus_rdata_i,
	output logic                     want_o,
	output logic                     stb_o,
	output logic                     we_o,
	output logic [md_pkg::VA_W-1:0]  addr_o,
	output logic [md_pkg::BE_W-1:0]  be_o,
	output logic [md_pkg::VD_W-1:0]  wdata_o,
	output logic                     cpu_ack_o,
	output logic [md_pkg::VD_W-1:0]  cpu_rdata_o
);

	logic pend_q;
	logic wait_drop_q;
	logic accept;
	logic finish;

	// new request only once the previous one has been released
	assign accept = cpu_req_i & ~pend_q & ~wait_drop_q;
	assign finish = stb_o & bus_ack_i;

	assign want_o = pend_q;
	assign stb_o = pend_q & grant_i;

	always_ff @(posedge MCLK2 or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			pend_q <= 1'b0;
			wait_drop_q <= 1'b0;
			cpu_ack_o <= 1'b0;
		end
		else
		begin
			cpu_ack_o <= finish;
			if (finish)
			begin
				pend_q <= 1'b0;
				wait_drop_q <= 1'b1;
			end
			else if (accept)
				pend_q <= 1'b1;
			else if (wait_drop_q & ~cpu_req_i)
				wait_drop_q <= 1'b0;
		end
	end

	// request fields and returned word
	always_ff @(posedge MCLK2)
	begin
		if (accept)
		begin
			we_o <= cpu_we_i;
			addr_o <= cpu_addr_i;
			be_o <= cpu_be_i;
			wdata_o <= cpu_wdata_i;
		end
		if (finish)
			cpu_rdata_o <= bus_rdata_i;
	end

endmodule

`default_nettype wire

// File: logic/md_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module md_bus_top #(
	parameter int RAM_AW = 15
) (
	input  wire                                MCLK2,
	input  wire                                arst_n_i,
	input  wire                                cpu_req_i,
	input  wire                                cpu_we_i,
	input  wire [md_pkg::VA_W-1:0]             cpu_addr_i,
	input  wire [md_pkg::BE_W-1:0]             cpu_be_i,
	input  wire [md_pkg::VD_W-1:0]             cpu_wdata_i,
	output logic                               cpu_ack_o,
	output logic [md_pkg::VD_W-1:0]            cpu_rdata_o,
	input  wire                                dma_start_i,
	input  wire [md_pkg::VA_W-1:0]             dma_src_i,
	input  wire [7:0]                          dma_len_i,
	input  wire                                dma_ready_i,
	output logic                               dma_valid_o,
	output logic [md_pkg::VD_W-1:0]            dma_data_o,
	output logic                               dma_busy_o,
	output logic                               dma_done_o,
	input  wire [md_pkg::FM_W-1:0]             fm_l_i,
	input  wire [md_pkg::FM_W-1:0]             fm_r_i,
	input  wire [md_pkg::FM2612_W-1:0]         fm2612_l_i,
	input  wire [md_pkg::FM2612_W-1:0]         fm2612_r_i,
	input  wire [md_pkg::PSG_W-1:0]            psg_i,
	output logic [md_pkg::MIX_W-1:0]           mix_l_o,
	output logic [md_pkg::MIX_W-1:0]           mix_r_o,
	output logic [md_pkg::MIX2612_W-1:0]       mix2612_l_o,
	output logic [md_pkg::MIX2612_W-1:0]       mix2612_r_o
);

	// ownership
	logic cpu_want;
	logic dma_want;
	logic cpu_grant;
	logic dma_grant;
	logic bus_busy;

	// cpu leg
	logic                      cpu_stb;
	logic                      cpu_we;
	logic [md_pkg::VA_W-1:0]   cpu_addr;
	logic [md_pkg::BE_W-1:0]   cpu_be;
	logic [md_pkg::VD_W-1:0]   cpu_wdata;

	// engine leg, read only
	logic                      dma_stb;
	logic [md_pkg::VA_W-1:0]   dma_addr;

	// shared bus
	logic                      bus_ack;
	logic [md_pkg::VD_W-1:0]   bus_rdata;
	logic                      ram_sel;
	logic                      ram_we;
	logic [md_pkg::VA_W-1:0]   ram_addr;
	logic [md_pkg::BE_W-1:0]   ram_be;
	logic [md_pkg::VD_W-1:0]   ram_wdata;
	logic                      ram_ack;
	logic [md_pkg::VD_W-1:0]   ram_rdata;

	cpu_bus_port cpu_bus_port_i (
		.MCLK2       (MCLK2),
		.arst_n_i    (arst_n_i),
		.cpu_req_i   (cpu_req_i),
		.cpu_we_i    (cpu_we_i),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_be_i    (cpu_be_i),
		.cpu_wdata_i (cpu_wdata_i),
		.grant_i     (cpu_grant),
		.bus_ack_i   (bus_ack),
		.bus_rdata_i (bus_rdata),
		.want_o      (cpu_want),
		.stb_o       (cpu_stb),
		.we_o        (cpu_we),
		.addr_o      (cpu_addr),
		.be_o        (cpu_be),
		.wdata_o     (cpu_wdata),
		.cpu_ack_o   (cpu_ack_o),
		.cpu_rdata_o (cpu_rdata_o)
	);

	block_dma block_dma_i (
		.MCLK2       (MCLK2),
		.arst_n_i    (arst_n_i),
		.dma_start_i (dma_start_i),
		.dma_src_i   (dma_src_i),
		.dma_len_i   (dma_len_i),
		.dma_ready_i (dma_ready_i),
		.grant_i     (dma_grant),
		.bus_ack_i   (bus_ack),
		.bus_rdata_i (bus_rdata),
		.want_o      (dma_want),
		.strobe_o    (dma_stb),
		.addr_o      (dma_addr),
		.dma_valid_o (dma_valid_o),
		.dma_data_o  (dma_data_o),
		.dma_busy_o  (dma_busy_o),
		.dma_done_o  (dma_done_o)
	);

	bus_arbiter bus_arbiter_i (
		.MCLK2       (MCLK2),
		.arst_n_i    (arst_n_i),
		.cpu_want_i  (cpu_want),
		.dma_want_i  (dma_want),
		.bus_busy_i  (bus_busy),
		.cpu_grant_o (cpu_grant),
		.dma_grant_o (dma_grant)
	);

	bus_fabric bus_fabric_i (
		.MCLK2       (MCLK2),
		.arst_n_i    (arst_n_i),
		.cpu_grant_i (cpu_grant),
		.dma_grant_i (dma_grant),
		.cpu_stb_i   (cpu_stb),
		.cpu_we_i    (cpu_we),
		.cpu_addr_i  (cpu_addr),
		.cpu_be_i    (cpu_be),
		.cpu_wdata_i (cpu_wdata),
		.dma_stb_i   (dma_stb),
		.dma_addr_i  (dma_addr),
		.ram_ack_i   (ram_ack),
		.ram_rdata_i (ram_rdata),
		.ram_sel_o   (ram_sel),
		.ram_we_o    (ram_we),
		.ram_addr_o  (ram_addr),
		.ram_be_o    (ram_be),
		.ram_wdata_o (ram_wdata),
		.bus_ack_o   (bus_ack),
		.bus_rdata_o (bus_rdata),
		.bus_busy_o  (bus_busy)
	);

	work_ram #(
		.RAM_AW (RAM_AW)
	) work_ram_i (
		.MCLK2       (MCLK2),
		.arst_n_i    (arst_n_i),
		.ram_sel_i   (ram_sel),
		.ram_we_i    (ram_we),
		.ram_addr_i  (ram_addr),
		.ram_be_i    (ram_be),
		.ram_wdata_i (ram_wdata),
		.ram_ack_o   (ram_ack),
		.ram_rdata_o (ram_rdata)
	);

	audio_mixer audio_mixer_i (
		.MCLK2       (MCLK2),
		.arst_n_i    (arst_n_i),
		.fm_l_i      (fm_l_i),
		.fm_r_i      (fm_r_i),
		.fm2612_l_i  (fm2612_l_i),
		.fm2612_r_i  (fm2612_r_i),
		.psg_i       (psg_i),
		.mix_l_o     (mix_l_o),
		.mix_r_o     (mix_r_o),
		.mix2612_l_o (mix2612_l_o),
		.mix2612_r_o (mix2612_r_o)
	);

endmodule

`default_nettype wire

// File: logic/md_pkg.sv
`default_nettype none

package md_pkg;

	// main bus geometry, word addressed
	localparam int VA_W = 23;
	localparam int VD_W = 16;
	localparam int BE_W = 2;

	// top two address bits that map work ram
	localparam logic [1:0] RAM_REGION = 2'b11;

	// audio widths
	// linear fm is offset binary, dac emulation fm is signed
	localparam int FM_W = 9;
	localparam int FM2612_W = 10;
	localparam int PSG_W = 16;
	localparam int MIX_W = 16;
	localparam int MIX2612_W = 18;

	// bus owner
	typedef enum logic {
		ARB_CPU,
		ARB_DMA
	} arb_state_e;

	// block transfer engine
	typedef enum logic [1:0] {
		DMA_IDLE,
		DMA_READ,
		DMA_HOLD,
		DMA_DONE
	} dma_state_e;

endpackage

`default_nettype wire

// File: logic/work_ram.sv
`timescale 1ns/1ps
`default_nettype none

module work_ram #(
	parameter int RAM_AW = 15
) (
	input  wire                      MCLK2,
	input  wire                      arst_n_i,
	input  wire                      ram_sel_i,
	input  wire                      ram_we_i,
	input  wire [md_pkg::VA_W-1:0]   ram_addr_i,
	input  wire [md_pkg::BE_W-1:0]   ram_be_i,
	input  wire [md_pkg::VD_W-1:0]   ram_wdata_i,
	output logic                     ram_ack_o,
	output logic [md_pkg::VD_W-1:0]  ram_rdata_o
);

	logic [md_pkg::VD_W-1:0] mem [2**RAM_AW];
	logic [RAM_AW-1:0]       idx;

	// upper address bits ignored, region mirrors
	assign idx = ram_addr_i[RAM_AW-1:0];

	always_ff @(posedge MCLK2)
	begin
		if (ram_sel_i)
		begin
			if (ram_we_i)
			begin
				for (int b = 0; b < md_pkg::BE_W; b++)
				begin
					if (ram_be_i[b])
						mem[idx][b*8 +: 8] <= ram_wdata_i[b*8 +: 8];
				end
			end
			ram_rdata_o <= mem[idx];
		end
	end

	always_ff @(posedge MCLK2 or negedge arst_n_i)
	begin
		if (!arst_n_i)
			ram_ack_o <= 1'b0;
		else
			ram_ack_o <= ram_sel_i;
	end

endmodule

`default_nettype wire
